// File: run_sim.sh
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sram_axi_bridge \
    --Mdir obj_dir -o sim \
    -f sram_axi_bridge.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim > "$LOG" 2>&1
rc=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $rc -ne 0 ]; then
    echo "simulation exited with status $rc"
    exit 1
fi
exit 0

// File: source/axi_pkg.sv
package axi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int ID_W   = 4;

    // read source, carried on arid and returned on rid
    typedef enum logic [ID_W-1:0] {
        ID_INST = 4'd0,
        ID_DATA = 4'd1
    } axi_id_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef struct packed {
        axi_id_e           id;
        logic [ADDR_W-1:0] addr;
        logic [2:0]        size;
    } axi_ar_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        axi_resp_e         resp;
        logic              last;
    } axi_r_t;

    // single write id, so no id field here
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [2:0]        size;
    } axi_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axi_w_t;

endpackage

// File: source/read_arbiter.sv
`timescale 1ns/1ps

module read_arbiter import axi_pkg::*, sram_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  sram_req_t inst_req,
    input  sram_req_t data_req,
    input  logic      inst_credit,
    input  logic      data_credit,
    input  logic      write_busy,
    output axi_ar_t   ar,
    output logic      arvalid,
    input  logic      arready,
    output logic      inst_addr_ok,
    output logic      data_rd_addr_ok
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DONE
    } state_e;

    state_e  state;
    state_e  state_nxt;
    axi_ar_t ar_q;
    logic    take_data;
    logic    take_inst;

    // data reads win, but never while a write is in flight
    assign take_data = data_req.en && !data_req.wr && !write_busy && data_credit;

    // a blocked data read does not hold up the instruction port
    assign take_inst = inst_req.en && inst_credit && !take_data;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (take_data || take_inst) begin
                    state_nxt = ISSUE;
                end
            end
            ISSUE: begin
                if (arready) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // latch the winner, payload stays put through back-pressure
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            if (take_data) begin
                ar_q.id   <= ID_DATA;
                ar_q.addr <= data_req.addr;
                ar_q.size <= {1'b0, data_req.size};
            end else if (take_inst) begin
                ar_q.id   <= ID_INST;
                ar_q.addr <= inst_req.addr;
                ar_q.size <= {1'b0, inst_req.size};
            end
        end
    end

    assign ar      = ar_q;
    assign arvalid = (state == ISSUE);

    // one cycle after the AR handshake
    assign inst_addr_ok    = (state == DONE) && (ar_q.id == ID_INST);
    assign data_rd_addr_ok = (state == DONE) && (ar_q.id == ID_DATA);

endmodule

// File: source/read_return.sv
`timescale 1ns/1ps

module read_return import axi_pkg::*, sram_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    input  logic              ar_fire,
    input  axi_id_e           ar_id,
    input  axi_r_t            r,
    input  logic              rvalid,
    output logic              rready,
    output logic              inst_credit,
    output logic              data_credit,
    output logic              data_reads_pending,
    output logic [DATA_W-1:0] inst_rdata,
    output logic [DATA_W-1:0] data_rdata,
    output logic              inst_data_ok,
    output logic              data_rd_data_ok
);

    // index 0 counts instruction reads, index 1 data reads
    logic [CNT_W-1:0]  cnt [2];
    logic [1:0]        inc;
    logic [1:0]        dec;
    logic              r_fire;
    logic              r_done;
    logic              r_is_data;
    logic              r_err;
    logic [DATA_W-1:0] r_word;

    assign r_fire    = rvalid && rready;
    assign r_done    = r_fire && r.last;
    assign r_is_data = (r.id == ID_DATA);
    assign r_err     = (r.resp == SLVERR) || (r.resp == DECERR);

    // errored reads hand back zero
    assign r_word = r_err ? '0 : r.data;

    assign inc = {ar_fire && (ar_id == ID_DATA), ar_fire && (ar_id == ID_INST)};
    assign dec = {r_done && r_is_data, r_done && !r_is_data};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cnt[0] <= '0;
            cnt[1] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                // issue and return in the same cycle cancel out
                case ({inc[i], dec[i]})
                    2'b10:   cnt[i] <= cnt[i] + CNT_W'(1);
                    2'b01:   cnt[i] <= cnt[i] - CNT_W'(1);
                    default: cnt[i] <= cnt[i];
                endcase
            end
        end
    end

    assign inst_credit        = (cnt[0] < CNT_W'(MAX_OUTSTANDING));
    assign data_credit        = (cnt[1] < CNT_W'(MAX_OUTSTANDING));
    assign data_reads_pending = (cnt[1] != '0);
    assign rready             = (cnt[0] != '0) || (cnt[1] != '0);

    always_ff @(posedge clk) begin
        if (r_fire) begin
            if (r_is_data) begin
                data_rdata <= r_word;
            end else begin
                inst_rdata <= r_word;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst_data_ok    <= 1'b0;
            data_rd_data_ok <= 1'b0;
        end else begin
            inst_data_ok    <= dec[0];
            data_rd_data_ok <= dec[1];
        end
    end

endmodule

// File: source/sram_axi_bridge.sv
`timescale 1ns/1ps

module sram_axi_bridge import axi_pkg::*, sram_pkg::*; (
    input  logic              clk,
    input  logic              resetn,
    // instruction port
    input  sram_req_t         inst_req,
    output logic [DATA_W-1:0] inst_rdata,
    output logic              inst_addr_ok,
    output logic              inst_data_ok,
    // data port
    input  sram_req_t         data_req,
    output logic [DATA_W-1:0] data_rdata,
    output logic              data_addr_ok,
    output logic              data_data_ok,
    // axi master
    output axi_ar_t           ar,
    output logic              arvalid,
    input  logic              arready,
    input  axi_r_t            r,
    input  logic              rvalid,
    output logic              rready,
    output axi_aw_t           aw,
    output logic              awvalid,
    input  logic              awready,
    output axi_w_t            w,
    output logic              wvalid,
    input  logic              wready,
    input  axi_resp_e         bresp,
    input  logic              bvalid,
    output logic              bready
);

    logic inst_credit;
    logic data_credit;
    logic data_reads_pending;
    logic write_busy;
    logic ar_fire;
    logic data_rd_addr_ok;
    logic data_wr_addr_ok;
    logic data_rd_data_ok;
    logic data_wr_data_ok;

    assign ar_fire = arvalid && arready;

    read_arbiter read_arbiter_i (
        .clk             (clk),
        .resetn          (resetn),
        .inst_req        (inst_req),
        .data_req        (data_req),
        .inst_credit     (inst_credit),
        .data_credit     (data_credit),
        .write_busy      (write_busy),
        .ar              (ar),
        .arvalid         (arvalid),
        .arready         (arready),
        .inst_addr_ok    (inst_addr_ok),
        .data_rd_addr_ok (data_rd_addr_ok)
    );

    read_return read_return_i (
        .clk                (clk),
        .resetn             (resetn),
        .ar_fire            (ar_fire),
        .ar_id              (ar.id),
        .r                  (r),
        .rvalid             (rvalid),
        .rready             (rready),
        .inst_credit        (inst_credit),
        .data_credit        (data_credit),
        .data_reads_pending (data_reads_pending),
        .inst_rdata         (inst_rdata),
        .data_rdata         (data_rdata),
        .inst_data_ok       (inst_data_ok),
        .data_rd_data_ok    (data_rd_data_ok)
    );

    write_channel write_channel_i (
        .clk                (clk),
        .resetn             (resetn),
        .data_req           (data_req),
        .data_reads_pending (data_reads_pending),
        .aw                 (aw),
        .awvalid            (awvalid),
        .awready            (awready),
        .w                  (w),
        .wvalid             (wvalid),
        .wready             (wready),
        .bresp              (bresp),
        .bvalid             (bvalid),
        .bready             (bready),
        .write_busy         (write_busy),
        .data_wr_addr_ok    (data_wr_addr_ok),
        .data_wr_data_ok    (data_wr_data_ok)
    );

    // reads and writes on the data port never overlap, so these never collide
    assign data_addr_ok = data_rd_addr_ok || data_wr_addr_ok;
    assign data_data_ok = data_rd_data_ok || data_wr_data_ok;

endmodule

// File: source/sram_pkg.sv
package sram_pkg;

    import axi_pkg::*;

    localparam int SIZE_W = 2;

    // reads in flight per port
    localparam int MAX_OUTSTANDING = 3;

    // wide enough to hold MAX_OUTSTANDING
    localparam int CNT_W = 2;

    // request is held by the master until addr_ok
    typedef struct packed {
        logic              en;
        logic              wr;
        logic [SIZE_W-1:0] size;
        logic [STRB_W-1:0] wstrb;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } sram_req_t;

endpackage

// File: source/write_channel.sv
`timescale 1ns/1ps

module write_channel import axi_pkg::*, sram_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  sram_req_t data_req,
    input  logic      data_reads_pending,
    output axi_aw_t   aw,
    output logic      awvalid,
    input  logic      awready,
    output axi_w_t    w,
    output logic      wvalid,
    input  logic      wready,
    input  axi_resp_e bresp,
    input  logic      bvalid,
    output logic      bready,
    output logic      write_busy,
    output logic      data_wr_addr_ok,
    output logic      data_wr_data_ok
);

    typedef enum logic [1:0] {
        IDLE,
        SEND,
        RESP,
        DONE
    } state_e;

    state_e  state;
    state_e  state_nxt;
    axi_aw_t aw_q;
    axi_w_t  w_q;
    logic    take;
    logic    aw_sent;
    logic    w_sent;
    logic    aw_fire;
    logic    w_fire;
    logic    both_sent;
    logic    b_fire;
    logic    b_retry;
    logic    resend;
    logic    addr_ok_q;

    // a write waits until every data read has returned
    assign take = data_req.en && data_req.wr && !data_reads_pending;

    assign awvalid   = (state == SEND) && !aw_sent;
    assign wvalid    = (state == SEND) && !w_sent;
    assign aw_fire   = awvalid && awready;
    assign w_fire    = wvalid && wready;
    assign both_sent = (aw_sent || aw_fire) && (w_sent || w_fire);
    assign bready    = (state == RESP);
    assign b_fire    = bvalid && bready;

    // slverr is taken as transient, the same beat goes out again
    assign b_retry = b_fire && (bresp == SLVERR);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (take) begin
                    state_nxt = SEND;
                end
            end
            SEND: begin
                if (both_sent) begin
                    state_nxt = RESP;
                end
            end
            RESP: begin
                if (b_retry) begin
                    state_nxt = SEND;
                end else if (b_fire) begin
                    state_nxt = DONE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= IDLE;
            aw_sent   <= 1'b0;
            w_sent    <= 1'b0;
            resend    <= 1'b0;
            addr_ok_q <= 1'b0;
        end else begin
            state <= state_nxt;
            // aw and w may finish in either order
            aw_sent <= (state == SEND) && (aw_sent || aw_fire);
            w_sent  <= (state == SEND) && (w_sent || w_fire);
            if (state == IDLE) begin
                resend <= 1'b0;
            end else if (b_retry) begin
                resend <= 1'b1;
            end
            // addr_ok only once per request, not again on a resend
            addr_ok_q <= (state == SEND) && both_sent && !resend;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == IDLE) && take) begin
            aw_q.addr <= data_req.addr;
            aw_q.size <= {1'b0, data_req.size};
            w_q.data  <= data_req.wdata;
            w_q.strb  <= data_req.wstrb;
        end
    end

    assign aw              = aw_q;
    assign w               = w_q;
    assign write_busy      = (state != IDLE);
    assign data_wr_addr_ok = addr_ok_q;
    assign data_wr_data_ok = (state == DONE);

endmodule

// File: sram_axi_bridge.f
source/axi_pkg.sv
source/sram_pkg.sv
source/read_arbiter.sv
source/read_return.sv
source/write_channel.sv
source/sram_axi_bridge.sv
tests/bridge_chk.sv
tests/tb_sram_axi_bridge.sv

// File: tests/bridge_chk.sv
`timescale 1ns/1ps

module bridge_chk import axi_pkg::*; (
    input logic    clk,
    input logic    resetn,
    input axi_ar_t ar,
    input logic    arvalid,
    input logic    arready,
    input axi_aw_t aw,
    input logic    awvalid,
    input logic    awready,
    input axi_w_t  w,
    input logic    wvalid,
    input logic    wready,
    input logic    inst_addr_ok,
    input logic    inst_data_ok,
    input logic    data_addr_ok,
    input logic    data_data_ok
);

    // requests accepted but not yet completed, per port
    logic [3:0] inst_open;
    logic [3:0] data_open;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst_open <= '0;
            data_open <= '0;
        end else begin
            inst_open <= inst_open + 4'(inst_addr_ok) - 4'(inst_data_ok);
            data_open <= data_open + 4'(data_addr_ok) - 4'(data_data_ok);
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!resetn)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("AR channel changed before arready");

    aw_hold: assert property (@(posedge clk) disable iff (!resetn)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("AW channel changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (!resetn)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("W channel changed before wready");

    inst_ok_open: assert property (@(posedge clk) disable iff (!resetn)
        inst_data_ok |-> inst_open != '0)
        else $error("inst_data_ok with nothing outstanding");

    data_ok_open: assert property (@(posedge clk) disable iff (!resetn)
        data_data_ok |-> data_open != '0)
        else $error("data_data_ok with nothing outstanding");

endmodule

bind sram_axi_bridge bridge_chk chk_i (.*);

// File: tests/bridge_vectors.txt
// port(0 inst, 1 data, f end) _ write _ addr _ wdata _ wstrb _ expected rdata
// writes carry a zero in the expected column
0_0_00000000_00000000_0_a5a50000
1_0_00000200_00000000_0_a5a50200
0_0_00000004_00000000_0_a5a50004
0_0_00000008_00000000_0_a5a50008
1_1_00000204_11223344_f_00000000
1_0_00000204_00000000_0_11223344
0_0_00000040_00000000_0_a5a50040
1_1_00000208_deadbeef_3_00000000
1_0_00000208_00000000_0_a5a5beef
0_0_00000044_00000000_0_a5a50044
1_1_0000020c_cafef00d_c_00000000
1_0_0000020c_00000000_0_cafe020c
0_0_000000a0_00000000_0_a5a500a0
1_0_00000210_00000000_0_a5a50210
1_0_00000214_00000000_0_a5a50214
0_0_000000b4_00000000_0_a5a500b4
1_1_00000218_00ff00ff_5_00000000
1_0_00000218_00000000_0_a5ff02ff
0_0_000000fc_00000000_0_a5a500fc
1_1_00000204_55667788_2_00000000
1_0_00000204_00000000_0_11227744
0_0_00000010_00000000_0_a5a50010
1_1_00000300_12345678_8_00000000
1_0_00000300_00000000_0_12a50300
0_0_00000080_00000000_0_a5a50080
1_0_000003fc_00000000_0_a5a503fc
1_1_000003fc_9abcdef0_1_00000000
1_0_000003fc_00000000_0_a5a503f0
0_0_000000c8_00000000_0_a5a500c8
1_0_00000208_00000000_0_a5a5beef
1_1_00000220_00000000_0_00000000
1_0_00000220_00000000_0_a5a50220
0_0_00000020_00000000_0_a5a50020
1_0_00000224_00000000_0_a5a50224
f_0_00000000_00000000_0_00000000

// File: tests/tb_sram_axi_bridge.sv
`timescale 1ns/1ps

module tb_sram_axi_bridge import axi_pkg::*, sram_pkg::*; ();

    logic              clk;
    logic              resetn;
    sram_req_t         inst_req;
    sram_req_t         data_req;
    logic [DATA_W-1:0] inst_rdata;
    logic [DATA_W-1:0] data_rdata;
    logic              inst_addr_ok;
    logic              inst_data_ok;
    logic              data_addr_ok;
    logic              data_data_ok;
    axi_ar_t           ar;
    logic              arvalid;
    logic              arready;
    axi_r_t            r;
    logic              rvalid;
    logic              rready;
    axi_aw_t           aw;
    logic              awvalid;
    logic              awready;
    axi_w_t            w;
    logic              wvalid;
    logic              wready;
    axi_resp_e         bresp;
    logic              bvalid;
    logic              bready;

    // port, write, addr, wdata, wstrb, expected
    logic [107:0]      vec [0:63];
    int                n_vec;
    bit                loaded;
    logic [31:0]       mem [0:255];
    axi_ar_t           rd_q [$];
    logic [31:0]       aw_addr_q [$];
    axi_w_t            w_q [$];
    logic [31:0]       inst_exp [$];
    logic [32:0]       data_exp [$];
    int                inst_accepted;
    int                inst_done;
    int                done_cnt;
    bit                hold_r;

    sram_axi_bridge dut_i (.*);

    always #2 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_idle_outputs();
        check_value("arvalid", {31'b0, arvalid}, 32'd0);
        check_value("awvalid", {31'b0, awvalid}, 32'd0);
        check_value("wvalid", {31'b0, wvalid}, 32'd0);
        check_value("rready", {31'b0, rready}, 32'd0);
        check_value("bready", {31'b0, bready}, 32'd0);
        check_value("inst_addr_ok", {31'b0, inst_addr_ok}, 32'd0);
        check_value("inst_data_ok", {31'b0, inst_data_ok}, 32'd0);
        check_value("data_addr_ok", {31'b0, data_addr_ok}, 32'd0);
        check_value("data_data_ok", {31'b0, data_data_ok}, 32'd0);
    endtask

    // replays every vector of one port, holding each request until addr_ok
    task automatic replay_port(input bit is_data);
        sram_req_t req;
        for (int i = 0; i < n_vec; i++) begin
            if (vec[i][104] == is_data) begin
                req.en    = 1'b1;
                req.wr    = vec[i][100];
                req.size  = 2'b10;
                req.addr  = vec[i][99:68];
                req.wdata = vec[i][67:36];
                req.wstrb = vec[i][35:32];
                @(posedge clk);
                #1;
                if (is_data) begin
                    data_req = req;
                    do @(negedge clk); while (!data_addr_ok);
                    data_exp.push_back({vec[i][100], vec[i][31:0]});
                end else begin
                    inst_req = req;
                    do @(negedge clk); while (!inst_addr_ok);
                    inst_exp.push_back(vec[i][31:0]);
                    inst_accepted++;
                end
            end
        end
        @(posedge clk);
        #1;
        if (is_data) data_req = '0;
        else inst_req = '0;
    endtask

    // slave: AR channel
    initial begin
        forever begin
            @(negedge clk);
            if (arvalid) begin
                repeat ($urandom % 4) @(negedge clk);
                @(posedge clk);
                #1 arready = 1'b1;
                @(negedge clk);
                // every request is a full word, four bytes
                check_value("arsize", {29'b0, ar.size}, 32'd2);
                rd_q.push_back(ar);
                @(posedge clk);
                #1 arready = 1'b0;
            end
        end
    end

    // slave: R channel, in order
    initial begin
        forever begin
            @(negedge clk);
            if (rd_q.size() != 0 && !hold_r) begin
                repeat ($urandom % 4) @(negedge clk);
                @(posedge clk);
                #1;
                r.id   = rd_q[0].id;
                r.data = mem[rd_q[0].addr[9:2]];
                r.resp = OKAY;
                r.last = 1'b1;
                rvalid = 1'b1;
                do @(negedge clk); while (!rready);
                @(posedge clk);
                #1 rvalid = 1'b0;
                void'(rd_q.pop_front());
            end
        end
    end

    // slave: AW channel
    initial begin
        forever begin
            @(negedge clk);
            if (awvalid) begin
                repeat ($urandom % 4) @(negedge clk);
                @(posedge clk);
                #1 awready = 1'b1;
                @(negedge clk);
                check_value("awsize", {29'b0, aw.size}, 32'd2);
                aw_addr_q.push_back(aw.addr);
                @(posedge clk);
                #1 awready = 1'b0;
            end
        end
    end

    // slave: W channel
    initial begin
        forever begin
            @(negedge clk);
            if (wvalid) begin
                repeat ($urandom % 4) @(negedge clk);
                @(posedge clk);
                #1 wready = 1'b1;
                @(negedge clk);
                w_q.push_back(w);
                @(posedge clk);
                #1 wready = 1'b0;
            end
        end
    end

    // slave: merge by strobe, then answer on B
    initial begin
        logic [7:0] idx;
        forever begin
            @(negedge clk);
            if (aw_addr_q.size() != 0 && w_q.size() != 0) begin
                idx = aw_addr_q[0][9:2];
                for (int b = 0; b < 4; b++) begin
                    if (w_q[0].strb[b]) mem[idx][8*b +: 8] = w_q[0].data[8*b +: 8];
                end
                void'(aw_addr_q.pop_front());
                void'(w_q.pop_front());
                repeat ($urandom % 4) @(negedge clk);
                @(posedge clk);
                #1 bvalid = 1'b1;
                do @(negedge clk); while (!bready);
                @(posedge clk);
                #1 bvalid = 1'b0;
            end
        end
    end

    // completions are matched against the oldest accepted request
    always @(negedge clk) begin
        if (resetn && loaded) begin
            if (inst_data_ok) begin
                if (inst_exp.size() == 0) report_failure("inst_data_ok with no request open");
                check_value("inst_rdata", inst_rdata, inst_exp.pop_front());
                inst_done++;
                done_cnt++;
            end
            if (data_data_ok) begin
                if (data_exp.size() == 0) report_failure("data_data_ok with no request open");
                if (!data_exp[0][32]) check_value("data_rdata", data_rdata, data_exp[0][31:0]);
                void'(data_exp.pop_front());
                done_cnt++;
            end
        end
    end

    // three instruction reads must all be accepted while R is held back
    initial begin
        hold_r = 1'b1;
        wait (loaded);
        for (int c = 0; c < 100 && inst_accepted < 3; c++) begin
            @(posedge clk);
        end
        check_value("inst_accepted", inst_accepted, 32'd3);
        hold_r = 1'b0;
    end

    initial begin
        wait (loaded);
        repeat (n_vec * 40) @(posedge clk);
        report_failure("timeout: not every vector completed in time");
    end

    initial begin
        clk      = 1'b0;
        resetn   = 1'b0;
        inst_req = '0;
        data_req = '0;
        arready  = 1'b0;
        r        = '0;
        rvalid   = 1'b0;
        awready  = 1'b0;
        wready   = 1'b0;
        bresp    = OKAY;
        bvalid   = 1'b0;
        loaded   = 1'b0;
        void'($urandom(85));
        for (int i = 0; i < 256; i++) begin
            mem[i] = {22'b0, i[7:0], 2'b00} ^ 32'ha5a50000;
        end
        $readmemh("tests/bridge_vectors.txt", vec);
        n_vec = 0;
        while (vec[n_vec][107:104] != 4'hf) n_vec++;
        repeat (2) @(posedge clk);
        #1 resetn = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        loaded = 1'b1;
        fork
            replay_port(1'b0);
            replay_port(1'b1);
        join
        wait (done_cnt == n_vec);
        repeat (4) @(posedge clk);
        if (inst_exp.size() == 0 && data_exp.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "requests left open at end of run");
        end
    end

endmodule
